// ==== tb.f ====
+incdir+source
source/mem_pkg.sv
source/mem_req_driver.sv
source/mem_bank.sv
source/rsp_merge.sv
source/mem_subsys_top.sv
bench/tb_clock.sv
bench/tb_mem_subsys.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the banked memory testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mem_subsys -f tb.f \
    -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { echo "build or run failed, see build.log and sim.log"; exit 1; }

grep -qx "TEST OK" sim.log \
    && echo "simulation passed" \
    || { echo "simulation did not pass, see sim.log"; exit 1; }

// ==== bench/tb_mem_subsys.sv ====
// Banked line memory testbench
// Directed tests against a reference memory model, with a response monitor
// that matches every read response by its line address

`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module tb_mem_subsys
    import mem_pkg::*;
;

    localparam int TIMEOUT = 300;
    localparam int RAND_STEPS = 100;
    localparam int DROP_STEPS = 60;

    logic       clk;
    logic       reset_n;
    line_addr_t mem_read_req_addr;
    logic       mem_read_req_enable;
    logic       mem_read_req_rdy;
    logic       mem_read_rsp_valid;
    line_addr_t mem_read_rsp_addr;
    line_data_t mem_read_rsp_data;
    line_addr_t mem_write_addr;
    line_data_t mem_write_data;
    logic       mem_write_enable;
    logic       mem_write_rdy;
    ack_count_t mem_write_ack;

    // Reference memory, updated in issue order with the write ahead of the read
    line_data_t ref_mem [line_addr_t];

    // Expected data of pending reads, one queue per line address
    line_data_t pend_q [1 << `MEM_ADDR_W][$];

    int          errors;
    int          tests_passed;
    int          tests_failed;
    int          writes_issued;
    int          reads_issued;
    int          reads_answered;
    int          ack_total;
    logic [31:0] lcg_state;

    tb_clock u_clock (
        .clk     (clk),
        .reset_n (reset_n)
    );

    mem_subsys_top u_dut (
        .clk                 (clk),
        .reset_n             (reset_n),
        .mem_read_req_addr   (mem_read_req_addr),
        .mem_read_req_enable (mem_read_req_enable),
        .mem_read_req_rdy    (mem_read_req_rdy),
        .mem_read_rsp_valid  (mem_read_rsp_valid),
        .mem_read_rsp_addr   (mem_read_rsp_addr),
        .mem_read_rsp_data   (mem_read_rsp_data),
        .mem_write_addr      (mem_write_addr),
        .mem_write_data      (mem_write_data),
        .mem_write_enable    (mem_write_enable),
        .mem_write_rdy       (mem_write_rdy),
        .mem_write_ack       (mem_write_ack)
    );

    // ========================================
    // Helpers
    // ========================================

    // Plain 32-bit linear congruential generator
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic check_eq(input string name, input logic [63:0] got,
                            input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("ERR t=%0t %s exp=%0h got=%0h", $time, name, exp, got);
            errors++;
        end
    endtask

    // Waits at falling edges for both ports to be ready
    // Called at a falling edge, where rdy already reflects this cycle's level
    task automatic wait_ready(output logic ok);
        int n;
        n = 0;
        while (!(mem_read_req_rdy && mem_write_rdy) && n < TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        ok = mem_read_req_rdy && mem_write_rdy;
        if (!ok)
        begin
            $display("t=%0t timed out waiting for the request ports to be ready", $time);
            errors++;
        end
    endtask

    // Holds the enables for one cycle, then leaves one idle cycle
    // The idle cycle lets the next rdy sample include these pushes
    task automatic drive_step(input logic do_wr, input line_addr_t wa,
                              input line_data_t wd, input logic do_rd,
                              input line_addr_t ra);
        @(posedge clk);
        mem_write_enable    <= do_wr;
        mem_write_addr      <= wa;
        mem_write_data      <= wd;
        mem_read_req_enable <= do_rd;
        mem_read_req_addr   <= ra;
        if (do_wr)
        begin
            ref_mem[wa] = wd;
            writes_issued++;
        end
        if (do_rd)
        begin
            pend_q[ra].push_back(ref_mem[ra]);
            reads_issued++;
        end
        @(posedge clk);
        mem_write_enable    <= 1'b0;
        mem_read_req_enable <= 1'b0;
    endtask

    task automatic issue(input logic do_wr, input line_addr_t wa, input line_data_t wd,
                         input logic do_rd, input line_addr_t ra);
        logic ok;
        @(negedge clk);
        wait_ready(ok);
        if (ok)
        begin
            drive_step(do_wr, wa, wd, do_rd, ra);
        end
    endtask

    // Waits until every read is answered and every write acknowledged
    task automatic wait_drain();
        int n;
        n = 0;
        while ((reads_answered < reads_issued || ack_total < writes_issued) && n < TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        if (reads_answered < reads_issued || ack_total < writes_issued)
        begin
            $display("t=%0t timed out waiting for responses, reads %0d of %0d, acks %0d of %0d",
                     $time, reads_answered, reads_issued, ack_total, writes_issued);
            errors++;
        end
    endtask

    task automatic check_totals();
        check_eq("write ack total", 64'(ack_total), 64'(writes_issued));
        check_eq("read response total", 64'(reads_answered), 64'(reads_issued));
    endtask

    task automatic report_test(input string name, input int start_errors);
        if (errors == start_errors)
        begin
            tests_passed++;
            $display("test %s: pass", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: fail, %0d errors", name, errors - start_errors);
        end
    endtask

    // ========================================
    // Response monitor
    // ========================================

    // Outputs are registered, so the falling edge sees them settled
    always @(negedge clk)
    begin : rsp_monitor
        line_data_t exp_data;
        if (reset_n)
        begin
            ack_total = ack_total + int'(mem_write_ack);
            if (mem_read_rsp_valid)
            begin
                if (pend_q[mem_read_rsp_addr].size() == 0)
                begin
                    $display("t=%0t read response for address %0h that has no pending read",
                             $time, mem_read_rsp_addr);
                    errors++;
                end
                else
                begin
                    exp_data = pend_q[mem_read_rsp_addr].pop_front();
                    check_eq("mem_read_rsp_data", mem_read_rsp_data, exp_data);
                    reads_answered++;
                end
            end
        end
    end

    // ========================================
    // Tests
    // ========================================

    task automatic check_reset_state();
        int start;
        int n;
        start = errors;
        n = 0;
        while (reset_n !== 1'b1 && n < TIMEOUT)
        begin
            @(posedge clk);
            n++;
        end
        if (reset_n !== 1'b1)
        begin
            $display("t=%0t reset was never released", $time);
            errors++;
        end
        @(negedge clk);
        check_eq("mem_read_req_rdy", 64'(mem_read_req_rdy), 64'd1);
        check_eq("mem_write_rdy", 64'(mem_write_rdy), 64'd1);
        check_eq("mem_read_rsp_valid", 64'(mem_read_rsp_valid), 64'd0);
        check_eq("mem_write_ack", 64'(mem_write_ack), 64'd0);
        report_test("reset state", start);
    endtask

    task automatic write_then_read();
        line_addr_t addrs [8];
        int start;
        start = errors;
        addrs = '{10'h000, 10'h001, 10'h002, 10'h003, 10'h005, 10'h00a, 10'h164, 10'h3ff};
        foreach (addrs[i])
        begin
            issue(1'b1, addrs[i], {lcg_next(), lcg_next()}, 1'b0, '0);
        end
        foreach (addrs[i])
        begin
            issue(1'b0, '0, '0, 1'b1, addrs[i]);
        end
        wait_drain();
        check_totals();
        report_test("write then read", start);
    endtask

    // The write is queued ahead of the read, so the read sees the new line
    task automatic same_cycle_write_read();
        int start;
        start = errors;
        issue(1'b1, 10'h2a5, 64'h0123_4567_89ab_cdef, 1'b0, '0);
        issue(1'b1, 10'h2a5, 64'hfedc_ba98_7654_3210, 1'b1, 10'h2a5);
        wait_drain();
        check_totals();
        report_test("same-cycle write and read", start);
    endtask

    // Two cycles per step, so about 200 cycles of traffic over 64 lines
    task automatic random_traffic();
        logic [31:0] r;
        logic [31:0] s;
        logic        do_wr;
        logic        do_rd;
        line_addr_t  wa;
        line_addr_t  ra;
        int          start;
        start = errors;
        for (int step = 0; step < RAND_STEPS; step++)
        begin
            r     = lcg_next();
            s     = lcg_next();
            do_wr = r[20];
            do_rd = r[21];
            wa    = line_addr_t'(r[27:22]);
            ra    = line_addr_t'(s[27:22]);
            // Only read lines whose contents the model knows
            if (!ref_mem.exists(ra) && !(do_wr && wa == ra))
            begin
                do_rd = 1'b0;
            end
            issue(do_wr, wa, {lcg_next(), lcg_next()}, do_rd, ra);
        end
        wait_drain();
        check_totals();
        report_test("random traffic", start);
    endtask

    // A write and a read to the same bank 1 line per step outrun the bank,
    // which needs three cycles for the pair, so its FIFO fills
    task automatic ready_drop_recovery();
        logic       saw_drop;
        logic       ok;
        line_addr_t a;
        int         start;
        start    = errors;
        saw_drop = 1'b0;
        for (int step = 0; step < DROP_STEPS && !saw_drop; step++)
        begin
            @(negedge clk);
            if (!mem_read_req_rdy)
            begin
                saw_drop = 1'b1;
            end
            else
            begin
                if (reads_issued - reads_answered > `MEM_FIFO_DEPTH)
                begin
                    $display("t=%0t ready still high with %0d reads in flight",
                             $time, reads_issued - reads_answered);
                    errors++;
                end
                a = line_addr_t'((step % 16) * 4 + 1);
                drive_step(1'b1, a, {lcg_next(), lcg_next()}, 1'b1, a);
            end
        end
        if (!saw_drop)
        begin
            $display("t=%0t read ready never dropped under sustained traffic", $time);
            errors++;
        end
        wait_ready(ok);
        wait_drain();
        check_totals();
        report_test("ready drop and recovery", start);
    endtask

    // ========================================
    // Main sequence
    // ========================================

    initial
    begin
        mem_read_req_addr   = '0;
        mem_read_req_enable = 1'b0;
        mem_write_addr      = '0;
        mem_write_data      = '0;
        mem_write_enable    = 1'b0;
        errors              = 0;
        tests_passed        = 0;
        tests_failed        = 0;
        writes_issued       = 0;
        reads_issued        = 0;
        reads_answered      = 0;
        ack_total           = 0;
        lcg_state           = 32'd49;

        check_reset_state();
        write_then_read();
        same_cycle_write_read();
        random_traffic();
        ready_drop_recovery();

        $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0)
        begin
            $display("TEST OK");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
// Testbench clock and reset source
// Free-running 8 ns clock with reset held low for the first five cycles

`timescale 1ns/1ps
`default_nettype none

module tb_clock
(
    output logic clk,
    output logic reset_n
);

    localparam int HALF_PERIOD = 4;
    localparam int RESET_CYCLES = 5;

    initial
    begin
        clk     = 1'b0;
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;
    end

    always #HALF_PERIOD clk = ~clk;

endmodule

`default_nettype wire

// ==== source/mem_subsys_top.sv ====
// Banked line memory subsystem
// Request driver, a row of identical banks and the response merger

`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module mem_subsys_top
    import mem_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,

    // Read request and response
    input  line_addr_t  mem_read_req_addr,
    input  logic        mem_read_req_enable,
    output logic        mem_read_req_rdy,
    output logic        mem_read_rsp_valid,
    output line_addr_t  mem_read_rsp_addr,
    output line_data_t  mem_read_rsp_data,

    // Write request and completion count
    input  line_addr_t  mem_write_addr,
    input  line_data_t  mem_write_data,
    input  logic        mem_write_enable,
    output logic        mem_write_rdy,
    output ack_count_t  mem_write_ack
);

    // ========================================
    // Driver to bank wiring
    // ========================================

    logic [`MEM_NUM_BANKS-1:0] wr_push;
    logic [`MEM_NUM_BANKS-1:0] rd_push;
    logic [`MEM_NUM_BANKS-1:0] bank_free_ge2;
    bank_word_t                wr_word;
    bank_word_t                rd_word;
    line_data_t                wr_data;

    // Bank to merger wiring, one element per bank
    logic [`MEM_NUM_BANKS-1:0] rsp_valid;
    logic [`MEM_NUM_BANKS-1:0] rsp_take;
    logic [`MEM_NUM_BANKS-1:0] wr_done;
    bank_word_t                rsp_word [`MEM_NUM_BANKS];
    line_data_t                rsp_data [`MEM_NUM_BANKS];

    mem_req_driver u_driver (
        .clk                 (clk),
        .reset_n             (reset_n),
        .mem_read_req_addr   (mem_read_req_addr),
        .mem_read_req_enable (mem_read_req_enable),
        .mem_read_req_rdy    (mem_read_req_rdy),
        .mem_write_addr      (mem_write_addr),
        .mem_write_data      (mem_write_data),
        .mem_write_enable    (mem_write_enable),
        .mem_write_rdy       (mem_write_rdy),
        .bank_free_ge2       (bank_free_ge2),
        .wr_push             (wr_push),
        .rd_push             (rd_push),
        .wr_word             (wr_word),
        .rd_word             (rd_word),
        .wr_data             (wr_data)
    );

    // One bank per select value, all fed the same shared payload
    for (genvar b = 0; b < `MEM_NUM_BANKS; b++)
    begin : g_bank
        mem_bank u_bank (
            .clk           (clk),
            .reset_n       (reset_n),
            .wr_push       (wr_push[b]),
            .wr_word       (wr_word),
            .wr_data       (wr_data),
            .rd_push       (rd_push[b]),
            .rd_word       (rd_word),
            .bank_free_ge2 (bank_free_ge2[b]),
            .rsp_valid     (rsp_valid[b]),
            .rsp_word      (rsp_word[b]),
            .rsp_data      (rsp_data[b]),
            .rsp_take      (rsp_take[b]),
            .wr_done       (wr_done[b])
        );
    end

    rsp_merge u_merge (
        .clk                (clk),
        .reset_n            (reset_n),
        .rsp_valid          (rsp_valid),
        .rsp_word           (rsp_word),
        .rsp_data           (rsp_data),
        .wr_done            (wr_done),
        .rsp_take           (rsp_take),
        .mem_read_rsp_valid (mem_read_rsp_valid),
        .mem_read_rsp_addr  (mem_read_rsp_addr),
        .mem_read_rsp_data  (mem_read_rsp_data),
        .mem_write_ack      (mem_write_ack)
    );

endmodule

`default_nettype wire

// ==== source/rsp_merge.sv ====
// Response merger
// Takes one held read response per cycle in round-robin order and counts
// the write-done pulses from all banks

`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module rsp_merge
    import mem_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset_n,

    // Bank side
    input  logic [`MEM_NUM_BANKS-1:0]   rsp_valid,
    input  bank_word_t                  rsp_word [`MEM_NUM_BANKS],
    input  line_data_t                  rsp_data [`MEM_NUM_BANKS],
    input  logic [`MEM_NUM_BANKS-1:0]   wr_done,
    output logic [`MEM_NUM_BANKS-1:0]   rsp_take,

    // Client side, all registered
    output logic                        mem_read_rsp_valid,
    output line_addr_t                  mem_read_rsp_addr,
    output line_data_t                  mem_read_rsp_data,
    output ack_count_t                  mem_write_ack
);

    bank_sel_t  last_grant;
    bank_sel_t  grant_idx;
    logic       grant_valid;
    ack_count_t ack_sum;

    // ========================================
    // Round-robin grant
    // ========================================

    // Search starts one past the last winner and wraps back to it
    always_comb
    begin
        bank_sel_t cand;

        grant_valid = 1'b0;
        grant_idx   = last_grant;
        for (int i = 1; i <= `MEM_NUM_BANKS; i++)
        begin
            cand = bank_sel_t'(int'(last_grant) + i);
            if (!grant_valid && rsp_valid[cand])
            begin
                grant_valid = 1'b1;
                grant_idx   = cand;
            end
        end

        rsp_take = '0;
        if (grant_valid)
        begin
            rsp_take[grant_idx] = 1'b1;
        end
    end

    // Sum of this cycle's write-done pulses
    always_comb
    begin
        ack_sum = '0;
        for (int b = 0; b < `MEM_NUM_BANKS; b++)
        begin
            ack_sum = ack_sum + ack_count_t'(wr_done[b]);
        end
    end

    // ========================================
    // Output registers
    // ========================================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            last_grant         <= '0;
            mem_read_rsp_valid <= 1'b0;
            mem_write_ack      <= '0;
        end
        else
        begin
            mem_read_rsp_valid <= grant_valid;
            mem_write_ack      <= ack_sum;
            if (grant_valid)
            begin
                last_grant <= grant_idx;
            end
        end
    end

    // Bank index goes back into the low address bits to rebuild the line
    always_ff @(posedge clk)
    begin
        if (grant_valid)
        begin
            mem_read_rsp_addr <= {rsp_word[grant_idx], grant_idx};
            mem_read_rsp_data <= rsp_data[grant_idx];
        end
    end

endmodule

`default_nettype wire

// ==== source/mem_bank.sv ====
// Memory bank
// In-order request FIFO taking up to two pushes per cycle, a 256-line RAM,
// a held read response and a one-cycle write-done pulse

`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module mem_bank
    import mem_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,

    // Requests from the driver
    input  logic        wr_push,
    input  bank_word_t  wr_word,
    input  line_data_t  wr_data,
    input  logic        rd_push,
    input  bank_word_t  rd_word,
    output logic        bank_free_ge2,

    // Read response, held until taken
    output logic        rsp_valid,
    output bank_word_t  rsp_word,
    output line_data_t  rsp_data,
    input  logic        rsp_take,

    // Pulses once per finished write
    output logic        wr_done
);

    localparam int PTR_W     = $clog2(`MEM_FIFO_DEPTH);
    localparam int CNT_W     = $clog2(`MEM_FIFO_DEPTH + 1);
    localparam int RAM_LINES = 1 << $bits(bank_word_t);

    // ========================================
    // Request FIFO
    // ========================================

    logic       fifo_is_wr [`MEM_FIFO_DEPTH];
    bank_word_t fifo_word  [`MEM_FIFO_DEPTH];
    line_data_t fifo_data  [`MEM_FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] rd_slot;
    logic [CNT_W-1:0] count;

    bank_state_t state;
    logic        pop;
    logic        head_is_wr;
    bank_word_t  head_word;
    line_data_t  head_data;

    // A same-cycle read lands one slot behind the write
    assign rd_slot = wr_ptr + PTR_W'(wr_push);

    // Room for two more entries keeps the driver's worst case safe
    assign bank_free_ge2 = (count <= CNT_W'(`MEM_FIFO_DEPTH - 2));

    // Entry storage has no reset, only the pointers and count matter
    always_ff @(posedge clk)
    begin
        if (wr_push)
        begin
            fifo_is_wr[wr_ptr] <= 1'b1;
            fifo_word[wr_ptr]  <= wr_word;
            fifo_data[wr_ptr]  <= wr_data;
        end
        if (rd_push)
        begin
            fifo_is_wr[rd_slot] <= 1'b0;
            fifo_word[rd_slot]  <= rd_word;
        end
    end

    assign head_is_wr = fifo_is_wr[rd_ptr];
    assign head_word  = fifo_word[rd_ptr];
    assign head_data  = fifo_data[rd_ptr];

    // Pop the oldest entry each cycle unless a read response is held
    assign pop = (state == BANK_RUN) && (count != '0);

    // ========================================
    // Control state
    // ========================================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state   <= BANK_RUN;
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            wr_done <= 1'b0;
        end
        else
        begin
            wr_ptr  <= wr_ptr + PTR_W'(wr_push) + PTR_W'(rd_push);
            rd_ptr  <= rd_ptr + PTR_W'(pop);
            count   <= count + CNT_W'(wr_push) + CNT_W'(rd_push) - CNT_W'(pop);
            wr_done <= pop && head_is_wr;

            // A popped read parks the bank until the merger takes it
            case (state)
                BANK_RUN:
                begin
                    if (pop && !head_is_wr)
                    begin
                        state <= BANK_HOLD;
                    end
                end
                BANK_HOLD:
                begin
                    if (rsp_take)
                    begin
                        state <= BANK_RUN;
                    end
                end
                default:
                begin
                    state <= BANK_RUN;
                end
            endcase
        end
    end

    // ========================================
    // Line RAM and response registers
    // ========================================

    line_data_t ram [RAM_LINES];

    // Writes land in the RAM at the pop, reads capture the line at the pop,
    // so a read queued behind a write to the same line sees the new data
    always_ff @(posedge clk)
    begin
        if (pop)
        begin
            if (head_is_wr)
            begin
                ram[head_word] <= head_data;
            end
            else
            begin
                rsp_word <= head_word;
                rsp_data <= ram[head_word];
            end
        end
    end

    assign rsp_valid = (state == BANK_HOLD);

    // The driver's ready rule must keep every push inside the FIFO
    a_fifo_no_overflow: assert property (@(posedge clk) disable iff (!reset_n)
        (int'(count) + int'(wr_push) + int'(rd_push)) <= `MEM_FIFO_DEPTH)
        else $error("mem_bank: request FIFO overflow");

    // The merger may only take a response that this bank is holding
    a_take_needs_valid: assert property (@(posedge clk) disable iff (!reset_n)
        rsp_take |-> rsp_valid)
        else $error("mem_bank: response taken while none was held");

endmodule

`default_nettype wire

// ==== source/mem_req_driver.sv ====
// Client request driver
// Splits read and write addresses into bank and word, forms per-bank push
// strobes and reports request readiness from the bank FIFO levels

`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module mem_req_driver
    import mem_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset_n,

    // Client read request
    input  line_addr_t                  mem_read_req_addr,
    input  logic                        mem_read_req_enable,
    output logic                        mem_read_req_rdy,

    // Client write request
    input  line_addr_t                  mem_write_addr,
    input  line_data_t                  mem_write_data,
    input  logic                        mem_write_enable,
    output logic                        mem_write_rdy,

    // Fill level summary from each bank
    input  logic [`MEM_NUM_BANKS-1:0]   bank_free_ge2,

    // Push strobes and shared payload toward the banks
    output logic [`MEM_NUM_BANKS-1:0]   wr_push,
    output logic [`MEM_NUM_BANKS-1:0]   rd_push,
    output bank_word_t                  wr_word,
    output bank_word_t                  rd_word,
    output line_data_t                  wr_data
);

    // ========================================
    // Address split
    // ========================================

    bank_sel_t wr_sel;
    bank_sel_t rd_sel;

    // Low bits select the bank and the rest address a line inside it
    assign wr_sel  = mem_write_addr[`MEM_BANK_SEL_W-1:0];
    assign wr_word = mem_write_addr[`MEM_ADDR_W-1:`MEM_BANK_SEL_W];
    assign rd_sel  = mem_read_req_addr[`MEM_BANK_SEL_W-1:0];
    assign rd_word = mem_read_req_addr[`MEM_ADDR_W-1:`MEM_BANK_SEL_W];

    // Write data goes to every bank, only the strobed one keeps it
    assign wr_data = mem_write_data;

    // ========================================
    // Push strobe decode
    // ========================================

    // One-hot decode of each select, gated by its enable
    // A read and a write may strobe the same bank in one cycle and the
    // bank orders the write first
    always_comb
    begin
        wr_push = '0;
        rd_push = '0;
        for (int b = 0; b < `MEM_NUM_BANKS; b++)
        begin
            if (mem_write_enable && (wr_sel == bank_sel_t'(b)))
            begin
                wr_push[b] = 1'b1;
            end
            if (mem_read_req_enable && (rd_sel == bank_sel_t'(b)))
            begin
                rd_push[b] = 1'b1;
            end
        end
    end

    // ========================================
    // Ready generation
    // ========================================

    // Both ports are ready only when every bank can take two more entries
    // That covers a read and a write landing on the same bank together,
    // wherever the next requests happen to go
    assign mem_read_req_rdy = &bank_free_ge2;
    assign mem_write_rdy    = &bank_free_ge2;

    // ========================================
    // Client protocol checks
    // ========================================

    // The client may raise an enable only while the matching rdy is high
    property p_enable_needs_rdy(logic en, logic rdy);
        @(posedge clk) disable iff (!reset_n)
            en |-> rdy;
    endproperty

    a_read_enable_rdy: assert property (p_enable_needs_rdy(mem_read_req_enable,
                                                           mem_read_req_rdy))
        else $error("mem_req_driver: read enable raised while not ready");

    a_write_enable_rdy: assert property (p_enable_needs_rdy(mem_write_enable,
                                                            mem_write_rdy))
        else $error("mem_req_driver: write enable raised while not ready");

endmodule

`default_nettype wire

// ==== source/mem_pkg.sv ====
// Banked line memory types
// Vector types for addresses, data and counts, plus the bank output state

`default_nettype none

`include "mem_defs.svh"

package mem_pkg;

    // Full line address as the client sees it
    typedef logic [`MEM_ADDR_W-1:0] line_addr_t;

    // One line of data
    typedef logic [`MEM_DATA_W-1:0] line_data_t;

    // Index of a bank, taken from the low address bits
    typedef logic [`MEM_BANK_SEL_W-1:0] bank_sel_t;

    // Line address inside one bank, i.e. the upper address bits
    typedef logic [`MEM_ADDR_W-`MEM_BANK_SEL_W-1:0] bank_word_t;

    // Writes finished in one cycle, 0 up to the bank count
    typedef logic [2:0] ack_count_t;

    // Bank output state
    // In BANK_RUN the bank pops its FIFO, in BANK_HOLD it waits on the merger
    typedef enum logic
    {
        BANK_RUN  = 1'b0,
        BANK_HOLD = 1'b1
    } bank_state_t;

endpackage

`default_nettype wire

// ==== source/mem_defs.svh ====
// Banked line memory parameters
// Address and data widths, bank layout and per-bank request FIFO depth

`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// ========================================
// Line geometry
// ========================================

// Width of a client line address, counted in lines and not bytes
`define MEM_ADDR_W      10

// Width of one cache line of data
`define MEM_DATA_W      64

// ========================================
// Bank layout
// ========================================

// Number of independent banks behind the request port
`define MEM_NUM_BANKS   4

// The low address bits pick the bank, so neighbouring lines spread out
`define MEM_BANK_SEL_W  2

// Entries in each bank request FIFO, kept a power of two so pointers wrap
`define MEM_FIFO_DEPTH  8

`endif
